// File: rtl/u1e_pkg.sv
package u1e_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // bus geometry
   localparam int DW     = 16;   // host bus data
   localparam int AW     = 11;   // byte address
   localparam int SW     = 2;
   localparam int SET_AW = 8;

   // setting register map, 32 bit regs
   localparam logic [SET_AW-1:0] SR_TIME64     = 8'd40;   // hi, lo, ctrl
   localparam logic [SET_AW-1:0] SR_REG_TEST32 = 8'd52;

   // slave numbers, top 4 address bits
   localparam logic [3:0] SLV_MISC     = 4'd0;
   localparam logic [3:0] SLV_READBACK = 4'd7;
   localparam logic [3:0] SLV_SETTINGS = 4'd8;   // 8 and 9, double wide

   // misc block byte offsets
   localparam logic [6:0] REG_LEDS      = 7'd0;
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;
   localparam logic [6:0] REG_TEST      = 7'd8;
   localparam logic [6:0] REG_COMPAT    = 7'd16;

   localparam logic [7:0]    COMPAT_NUM  = 8'd3;
   localparam logic [DW-1:0] UNMAPPED_RD = 16'hBEEF;

   ////////////////////////////////////////////////////////////////////////////
   // bus types
   typedef union packed {
      struct packed {
         logic [3:0]    slave;
         logic [AW-5:0] offset;
      } slv;
      struct packed {
         logic [2:0] win;        // settings window
         logic [5:0] reg_idx;
         logic       half;       // high half fires the strobe
         logic       byte_bit;
      } sbus;
   } wb_addr_u;

   typedef struct packed {
      wb_addr_u      adr;
      logic [DW-1:0] dat;
      logic [SW-1:0] sel;
      logic          we;
      logic          cyc;
      logic          stb;
   } wb_req_t;

   typedef struct packed {
      logic [DW-1:0] dat;
      logic          ack;
   } wb_rsp_t;

   typedef struct packed {
      logic              stb;
      logic [SET_AW-1:0] addr;
      logic [2*DW-1:0]   data;
   } set_bus_t;

   typedef struct packed {
      logic status;
      logic ld;       // lock detect
      logic refmon;
   } cgen_st_t;

endpackage

// File: rtl/wb_intercon.sv
`timescale 1ns/1ps

module wb_intercon
  (input  logic             wb_clk,
   input  u1e_pkg::wb_req_t wb_req_i,
   output u1e_pkg::wb_rsp_t wb_rsp_o,
   output u1e_pkg::wb_req_t misc_req_o,
   input  u1e_pkg::wb_rsp_t misc_rsp_i,
   output u1e_pkg::wb_req_t rb_req_o,
   input  u1e_pkg::wb_rsp_t rb_rsp_i,
   output u1e_pkg::wb_req_t set_req_o,
   input  u1e_pkg::wb_rsp_t set_rsp_i
   );

   logic hit_misc;
   logic hit_rb;
   logic hit_set;

   ////////////////////////////////////////////////////////////////////////////
   // slave decode
   assign hit_misc = (wb_req_i.adr.slv.slave == u1e_pkg::SLV_MISC);
   assign hit_rb   = (wb_req_i.adr.slv.slave == u1e_pkg::SLV_READBACK);
   // low decode bit ignored, so 8 and 9 both land here
   assign hit_set  = (wb_req_i.adr.sbus.win == u1e_pkg::SLV_SETTINGS[3:1]);

   // everything but stb fans out unchanged
   always_comb
   begin
      misc_req_o     = wb_req_i;
      rb_req_o       = wb_req_i;
      set_req_o      = wb_req_i;
      misc_req_o.stb = wb_req_i.stb & hit_misc;
      rb_req_o.stb   = wb_req_i.stb & hit_rb;
      set_req_o.stb  = wb_req_i.stb & hit_set;
   end

   ////////////////////////////////////////////////////////////////////////////
   // response mux
   always_comb
   begin
      wb_rsp_o = '0;                // unmapped, never acks
      if (hit_misc)
         wb_rsp_o = misc_rsp_i;
      else if (hit_rb)
         wb_rsp_o = rb_rsp_i;
      else if (hit_set)
         wb_rsp_o = set_rsp_i;
   end

   // an ack only comes back from the one slave that was strobed
   a_one_slave : assert property (@(posedge wb_clk)
      wb_rsp_o.ack |-> $onehot({misc_req_o.stb, rb_req_o.stb, set_req_o.stb}))
      else
         $error("wb_intercon: ack without exactly one slave strobed");

endmodule

// File: rtl/misc_regs.sv
`timescale 1ns/1ps

module misc_regs
  (input  logic              wb_clk,
   input  logic              wb_rst,
   input  u1e_pkg::wb_req_t  req_i,
   output u1e_pkg::wb_rsp_t  rsp_o,
   input  u1e_pkg::cgen_st_t cgen_st_i,
   output logic [3:0]        debug_led_o,
   output logic              cgen_sync_b_o,
   output logic              cgen_ref_sel_o
   );

   logic [u1e_pkg::DW-1:0] reg_leds;
   logic [u1e_pkg::DW-1:0] reg_cgen_ctrl;
   logic [u1e_pkg::DW-1:0] reg_test;
   logic                   wr_en;

   assign wr_en = req_i.cyc & req_i.stb & req_i.we;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= 16'h0003;    // sync_b and ref_sel idle high
         reg_test      <= '0;
      end
      else if (wr_en)
      begin
         case (req_i.adr.slv.offset)
            u1e_pkg::REG_LEDS      : reg_leds      <= req_i.dat;
            u1e_pkg::REG_CGEN_CTRL : reg_cgen_ctrl <= req_i.dat;
            u1e_pkg::REG_TEST      : reg_test      <= req_i.dat;
            default                : ;
         endcase
      end
   end

   // leds are active low, upper two are the old run lines
   assign debug_led_o    = ~{2'b00, reg_leds[1:0]};
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

   ////////////////////////////////////////////////////////////////////////////
   // readback
   always_comb
   begin
      case (req_i.adr.slv.offset)
         u1e_pkg::REG_LEDS      : rsp_o.dat = reg_leds;
         u1e_pkg::REG_CGEN_CTRL : rsp_o.dat = reg_cgen_ctrl;
         u1e_pkg::REG_CGEN_ST   : rsp_o.dat = {13'd0, cgen_st_i};
         u1e_pkg::REG_TEST      : rsp_o.dat = reg_test;
         u1e_pkg::REG_COMPAT    : rsp_o.dat = {8'd0, u1e_pkg::COMPAT_NUM};
         default                : rsp_o.dat = u1e_pkg::UNMAPPED_RD;
      endcase
   end

   assign rsp_o.ack = req_i.cyc & req_i.stb;

endmodule

// File: rtl/settings_bus_16le.sv
`timescale 1ns/1ps

module settings_bus_16le
  (input  logic              wb_clk,
   input  logic              wb_rst,
   input  u1e_pkg::wb_req_t  req_i,
   output u1e_pkg::wb_rsp_t  rsp_o,
   output u1e_pkg::set_bus_t set_o
   );

   logic                       wr_en;
   logic [u1e_pkg::DW-1:0]     data_lo;    // held until the high half arrives
   logic                       stb_r;
   logic [u1e_pkg::SET_AW-1:0] addr_r;
   logic [2*u1e_pkg::DW-1:0]   data_r;

   assign wr_en = req_i.cyc & req_i.stb & req_i.we;

   always_ff @(posedge wb_clk)
   begin
      if (wr_en && !req_i.adr.sbus.half)
         data_lo <= req_i.dat;
   end

   // high half write fires a one cycle strobe
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         stb_r <= 1'b0;
      else
         stb_r <= wr_en & req_i.adr.sbus.half;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_en && req_i.adr.sbus.half)
      begin
         addr_r <= u1e_pkg::SET_AW'(req_i.adr.sbus.reg_idx);
         data_r <= {req_i.dat, data_lo};
      end
   end

   assign set_o = '{stb: stb_r, addr: addr_r, data: data_r};

   assign rsp_o.dat = '0;   // write only
   assign rsp_o.ack = req_i.cyc & req_i.stb;

   a_stb_pulse : assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_o.stb |=> !set_o.stb)
      else
         $error("settings_bus_16le: setting strobe held two cycles");

endmodule

// File: rtl/time_64bit.sv
`timescale 1ns/1ps

module time_64bit
  (input  logic              wb_clk,
   input  logic              wb_rst,
   input  u1e_pkg::set_bus_t set_i,
   input  logic              pps_i,
   output logic [63:0]       vita_time_o,
   output logic [63:0]       vita_time_pps_o
   );

   logic [31:0] time_hi;
   logic [31:0] time_lo;
   logic        hit_hi, hit_lo, hit_ctrl;
   logic        armed;          // load waits for pps
   logic [1:0]  pps_sync;
   logic        pps_del;
   logic        pps_edge;

   assign hit_hi   = set_i.stb && (set_i.addr == u1e_pkg::SR_TIME64);
   assign hit_lo   = set_i.stb && (set_i.addr == u1e_pkg::SR_TIME64 + 8'd1);
   assign hit_ctrl = set_i.stb && (set_i.addr == u1e_pkg::SR_TIME64 + 8'd2);

   // staging for the next load
   always_ff @(posedge wb_clk)
   begin
      if (hit_hi)
         time_hi <= set_i.data;
      if (hit_lo)
         time_lo <= set_i.data;
   end

   ////////////////////////////////////////////////////////////////////////////
   // pps sync and rising edge
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync <= 2'b00;
         pps_del  <= 1'b0;
      end
      else
      begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_del  <= pps_sync[1];
      end
   end

   assign pps_edge = pps_sync[1] & ~pps_del;

   ////////////////////////////////////////////////////////////////////////////
   // counter, immediate load wins over pps load
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         vita_time_o <= '0;
         armed       <= 1'b0;
      end
      else if (hit_ctrl && set_i.data[0])
      begin
         vita_time_o <= {time_hi, time_lo};
         armed       <= 1'b0;
      end
      else
      begin
         if (pps_edge && armed)
            vita_time_o <= {time_hi, time_lo};
         else
            vita_time_o <= vita_time_o + 64'd1;
         if (hit_ctrl)
            armed <= 1'b1;
         else if (pps_edge)
            armed <= 1'b0;  // consumed
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         vita_time_pps_o <= '0;
      else if (pps_edge)
         vita_time_pps_o <= vita_time_o;
   end

endmodule

// File: rtl/readback_mux_16le.sv
`timescale 1ns/1ps

module readback_mux_16le
  (input  logic              wb_clk,
   input  logic              wb_rst,
   input  u1e_pkg::wb_req_t  req_i,
   output u1e_pkg::wb_rsp_t  rsp_o,
   input  u1e_pkg::set_bus_t set_i,
   input  logic [63:0]       vita_time_i,
   input  logic [63:0]       vita_time_pps_i
   );

   logic [2*u1e_pkg::DW-1:0] reg_test32;
   logic [2*u1e_pkg::DW-1:0] word;

   // host scratch register on the settings bus
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         reg_test32 <= '0;
      else if (set_i.stb && (set_i.addr == u1e_pkg::SR_REG_TEST32))
         reg_test32 <= set_i.data;
   end

   ////////////////////////////////////////////////////////////////////////////
   // word select, then half
   always_comb
   begin
      case (req_i.adr.slv.offset[5:2])
         4'd0    : word = vita_time_i[63:32];
         4'd1    : word = vita_time_i[31:0];
         4'd2    : word = vita_time_pps_i[63:32];
         4'd3    : word = vita_time_pps_i[31:0];
         4'd4    : word = reg_test32;
         default : word = '0;
      endcase
   end

   assign rsp_o.dat = req_i.adr.slv.offset[1] ? word[31:16] : word[15:0];
   assign rsp_o.ack = req_i.cyc & req_i.stb;

   a_rd_known : assert property (@(posedge wb_clk) disable iff (wb_rst)
      rsp_o.ack |-> !$isunknown(rsp_o.dat))
      else
         $error("readback_mux_16le: unknown read data on ack");

endmodule

// File: rtl/u1e_core.sv
`timescale 1ns/1ps

module u1e_core
  (input  logic               wb_clk,
   input  logic               wb_rst,
   input  u1e_pkg::wb_req_t   wb_req_i,
   output u1e_pkg::wb_rsp_t   wb_rsp_o,
   input  u1e_pkg::cgen_st_t  cgen_st_i,
   input  logic               pps_i,
   output logic [3:0]         debug_led_o,
   output logic               cgen_sync_b_o,
   output logic               cgen_ref_sel_o
   );

   u1e_pkg::wb_req_t  misc_req, rb_req, set_req;
   u1e_pkg::wb_rsp_t  misc_rsp, rb_rsp, set_rsp;
   u1e_pkg::set_bus_t set_bus;

   logic [63:0] vita_time, vita_time_pps;

   ////////////////////////////////////////////////////////////////////////////
   // single master decode
   wb_intercon i_intercon
     (.wb_clk     (wb_clk),
      .wb_req_i   (wb_req_i),
      .wb_rsp_o   (wb_rsp_o),
      .misc_req_o (misc_req),
      .misc_rsp_i (misc_rsp),
      .rb_req_o   (rb_req),
      .rb_rsp_i   (rb_rsp),
      .set_req_o  (set_req),
      .set_rsp_i  (set_rsp));

   // slave 0
   misc_regs i_misc_regs
     (.wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .req_i          (misc_req),
      .rsp_o          (misc_rsp),
      .cgen_st_i      (cgen_st_i),
      .debug_led_o    (debug_led_o),
      .cgen_sync_b_o  (cgen_sync_b_o),
      .cgen_ref_sel_o (cgen_ref_sel_o));

   // slaves 8 and 9
   settings_bus_16le i_settings_bus
     (.wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .req_i  (set_req),
      .rsp_o  (set_rsp),
      .set_o  (set_bus));

   ////////////////////////////////////////////////////////////////////////////
   // vita time and its readback
   time_64bit i_time_64bit
     (.wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .set_i           (set_bus),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps));

   readback_mux_16le i_readback_mux   // slave 7
     (.wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .req_i           (rb_req),
      .rsp_o           (rb_rsp),
      .set_i           (set_bus),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps));

endmodule

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
  (output logic wb_clk,
   output logic wb_rst
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #4 wb_clk = ~wb_clk;   // 8 ns period
   end

   initial
   begin
      wb_rst = 1'b1;
      repeat (8) @(posedge wb_clk);
      wb_rst <= 1'b0;
   end

endmodule

// File: tests/tb_u1e_core.sv
`timescale 1ns/1ps

module tb_u1e_core;

   localparam int          N_OPS      = 100;
   localparam int          OP_CYCLES  = 44;    // armed pps load is the longest op
   localparam int          MAX_CYCLES = N_OPS * OP_CYCLES + 100;
   localparam logic [31:0] SEED       = 32'h2d38c282;

   logic              wb_clk;
   logic              wb_rst;
   u1e_pkg::wb_req_t  wb_req;
   u1e_pkg::wb_rsp_t  wb_rsp;
   u1e_pkg::cgen_st_t cgen_st;
   logic              pps;
   logic [3:0]        debug_led;
   logic              cgen_sync_b;
   logic              cgen_ref_sel;

   int          cycle;
   int          smp_edge;     // edge count when the last access was sampled
   int          err_val;
   int          err_ack;
   int          op;
   logic [15:0] rd_data;

   // reference model state
   logic [15:0] m_leds;
   logic [15:0] m_cgen;
   logic [15:0] m_test;
   logic [63:0] m_time_base;
   int          m_load_edge;

   tb_clk_gen i_clk_gen (.wb_clk(wb_clk), .wb_rst(wb_rst));

   u1e_core i_dut
     (.wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .wb_req_i       (wb_req),
      .wb_rsp_o       (wb_rsp),
      .cgen_st_i      (cgen_st),
      .pps_i          (pps),
      .debug_led_o    (debug_led),
      .cgen_sync_b_o  (cgen_sync_b),
      .cgen_ref_sel_o (cgen_ref_sel));

   always @(posedge wb_clk)
   begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES)
      begin
         $display("timeout, run still going after %0d cycles", cycle);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // address and request builders
   function automatic u1e_pkg::wb_addr_u slave_adr(input logic [3:0] slv,
                                                   input logic [6:0] off);
      u1e_pkg::wb_addr_u a;
      a.slv.slave  = slv;
      a.slv.offset = off;
      return a;
   endfunction

   function automatic u1e_pkg::wb_addr_u set_adr(input logic [7:0] idx, input logic half);
      u1e_pkg::wb_addr_u a;
      a.sbus.win      = 3'b100;     // slaves 8 and 9
      a.sbus.reg_idx  = idx[5:0];
      a.sbus.half     = half;
      a.sbus.byte_bit = 1'b0;
      return a;
   endfunction

   function automatic u1e_pkg::wb_addr_u rb_adr(input logic [3:0] word, input logic half);
      return slave_adr(u1e_pkg::SLV_READBACK, {1'b0, word, half, 1'b0});
   endfunction

   function automatic u1e_pkg::wb_req_t make_req(input u1e_pkg::wb_addr_u adr,
                                                 input logic we, input logic [15:0] dat);
      u1e_pkg::wb_req_t r;
      r.adr = adr;
      r.dat = dat;
      r.sel = 2'b11;
      r.we  = we;
      r.cyc = 1'b1;
      r.stb = 1'b1;
      return r;
   endfunction

   // time counts up one per edge from the last load
   function automatic logic [63:0] model_time(input int at_edge);
      return m_time_base + 64'(at_edge - m_load_edge);
   endfunction

   function automatic logic [15:0] misc_expect(input logic [6:0] off);
      case (off)
         u1e_pkg::REG_LEDS      : return m_leds;
         u1e_pkg::REG_CGEN_CTRL : return m_cgen;
         u1e_pkg::REG_CGEN_ST   : return {13'd0, cgen_st};
         u1e_pkg::REG_TEST      : return m_test;
         u1e_pkg::REG_COMPAT    : return 16'd3;
         default                : return 16'hBEEF;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
      err_val++;
      $display("ERR %0t %s exp %0h got %0h", $time, name, exp, act);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // bus accesses, ack comes in the same cycle
   task automatic bus_access(input u1e_pkg::wb_addr_u adr, input logic we,
                             input logic [15:0] dat);
      @(posedge wb_clk);
      wb_req  <= make_req(adr, we, dat);
      cgen_st <= u1e_pkg::cgen_st_t'($urandom);
      @(negedge wb_clk);
      rd_data  = wb_rsp.dat;
      smp_edge = cycle;               // a write lands on the next edge
      if (!wb_rsp.ack)
      begin
         err_ack++;
         $display("%0t: slave %0d gave no ack on a mapped access", $time, adr.slv.slave);
      end
      @(posedge wb_clk);
      wb_req <= '0;
   endtask

   task automatic set_write(input logic [7:0] idx, input logic [31:0] val);
      bus_access(set_adr(idx, 1'b0), 1'b1, val[15:0]);
      bus_access(set_adr(idx, 1'b1), 1'b1, val[31:16]);
   endtask

   task automatic check_time_low();
      logic [63:0] exp;
      repeat ($urandom_range(0, 8)) @(posedge wb_clk);
      bus_access(rb_adr(4'd1, 1'b0), 1'b0, 16'h0);
      exp = model_time(smp_edge);
      if (rd_data !== exp[15:0])
         report_mismatch("vita_time[15:0]", exp[15:0], rd_data);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // random operations
   task automatic misc_op();
      logic [6:0]  off;
      logic [15:0] val;
      case ($urandom_range(0, 5))
         0       : off = u1e_pkg::REG_LEDS;
         1       : off = u1e_pkg::REG_CGEN_CTRL;
         2       : off = u1e_pkg::REG_CGEN_ST;
         3       : off = u1e_pkg::REG_TEST;
         4       : off = u1e_pkg::REG_COMPAT;
         default : off = 7'($urandom);      // mostly unknown offsets
      endcase
      val = 16'($urandom);
      if ($urandom_range(0, 1) == 1)
      begin
         bus_access(slave_adr(u1e_pkg::SLV_MISC, off), 1'b1, val);
         case (off)
            u1e_pkg::REG_LEDS      : m_leds = val;
            u1e_pkg::REG_CGEN_CTRL : m_cgen = val;
            u1e_pkg::REG_TEST      : m_test = val;
            default                : ;
         endcase
         @(negedge wb_clk);
         if (debug_led !== ~{2'b00, m_leds[1:0]})
            report_mismatch("debug_led_o", ~{2'b00, m_leds[1:0]}, debug_led);
         if (cgen_sync_b !== m_cgen[1])
            report_mismatch("cgen_sync_b_o", m_cgen[1], cgen_sync_b);
         if (cgen_ref_sel !== m_cgen[0])
            report_mismatch("cgen_ref_sel_o", m_cgen[0], cgen_ref_sel);
      end
      else
      begin
         bus_access(slave_adr(u1e_pkg::SLV_MISC, off), 1'b0, 16'h0);
         if (rd_data !== misc_expect(off))
            report_mismatch("misc rd_data", misc_expect(off), rd_data);
      end
   endtask

   task automatic test32_op();
      logic [31:0] val;
      val = $urandom;
      set_write(u1e_pkg::SR_REG_TEST32, val);
      bus_access(rb_adr(4'd4, 1'b0), 1'b0, 16'h0);
      if (rd_data !== val[15:0])
         report_mismatch("reg_test32[15:0]", val[15:0], rd_data);
      bus_access(rb_adr(4'd4, 1'b1), 1'b0, 16'h0);
      if (rd_data !== val[31:16])
         report_mismatch("reg_test32[31:16]", val[31:16], rd_data);
   endtask

   task automatic stage_time(input logic [63:0] val, input logic now);
      set_write(u1e_pkg::SR_TIME64, val[63:32]);
      set_write(8'(u1e_pkg::SR_TIME64 + 8'd1), val[31:0]);
      set_write(8'(u1e_pkg::SR_TIME64 + 8'd2), {31'd0, now});
   endtask

   task automatic time_load_op();
      logic [63:0] val;
      val = {$urandom, $urandom};
      stage_time(val, 1'b1);
      m_time_base = val;
      m_load_edge = smp_edge + 2;     // strobe on the write edge, load one later
      check_time_low();
   endtask

   task automatic pps_op();
      logic        armed;
      logic [63:0] stage;
      logic [63:0] exp_pps;
      int          rise;
      armed = 1'($urandom_range(0, 1));
      stage = {$urandom, $urandom};
      if (armed)
         stage_time(stage, 1'b0);
      repeat ($urandom_range(1, 6)) @(posedge wb_clk);
      pps <= 1'b1;
      @(negedge wb_clk);
      rise = cycle;
      // two sync flops and the edge flop, capture on the third edge
      exp_pps = model_time(rise + 2);
      if (armed)
      begin
         m_time_base = stage;
         m_load_edge = rise + 3;
      end
      repeat (4) @(posedge wb_clk);
      pps <= 1'b0;
      repeat (3) @(posedge wb_clk);
      bus_access(rb_adr(4'd2, 1'b0), 1'b0, 16'h0);
      if (rd_data !== exp_pps[47:32])
         report_mismatch("vita_time_pps[47:32]", exp_pps[47:32], rd_data);
      bus_access(rb_adr(4'd2, 1'b1), 1'b0, 16'h0);
      if (rd_data !== exp_pps[63:48])
         report_mismatch("vita_time_pps[63:48]", exp_pps[63:48], rd_data);
      bus_access(rb_adr(4'd3, 1'b0), 1'b0, 16'h0);
      if (rd_data !== exp_pps[15:0])
         report_mismatch("vita_time_pps[15:0]", exp_pps[15:0], rd_data);
      bus_access(rb_adr(4'd3, 1'b1), 1'b0, 16'h0);
      if (rd_data !== exp_pps[31:16])
         report_mismatch("vita_time_pps[31:16]", exp_pps[31:16], rd_data);
      check_time_low();
   endtask

   task automatic unmapped_op();
      logic [3:0] slv;
      if ($urandom_range(0, 1) == 1)
         slv = 4'($urandom_range(1, 6));
      else
         slv = 4'($urandom_range(10, 15));
      @(posedge wb_clk);
      wb_req <= make_req(slave_adr(slv, 7'($urandom)), 1'b0, 16'h0);
      repeat (4)
      begin
         @(negedge wb_clk);
         if (wb_rsp.ack)
         begin
            err_ack++;
            $display("%0t: unmapped slave %0d acknowledged", $time, slv);
         end
      end
      @(posedge wb_clk);
      wb_req <= '0;                   // master gives up
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   initial
   begin
      void'($urandom(SEED));
      wb_req      = '0;
      cgen_st     = '0;
      pps         = 1'b0;
      m_leds      = '0;
      m_cgen      = 16'h0003;         // sync_b and ref_sel high after reset
      m_test      = '0;
      m_time_base = '0;
      m_load_edge = 0;
      wait (wb_rst === 1'b0);
      @(negedge wb_clk);
      if (debug_led !== 4'hF)
         report_mismatch("debug_led_o", 4'hF, debug_led);
      if (cgen_sync_b !== 1'b1)
         report_mismatch("cgen_sync_b_o", 1'b1, cgen_sync_b);
      if (cgen_ref_sel !== 1'b1)
         report_mismatch("cgen_ref_sel_o", 1'b1, cgen_ref_sel);
      bus_access(slave_adr(u1e_pkg::SLV_MISC, u1e_pkg::REG_COMPAT), 1'b0, 16'h0);
      if (rd_data !== 16'd3)
         report_mismatch("compat rd_data", 16'd3, rd_data);

      time_load_op();                 // model time known from here on
      for (op = 0; op < N_OPS; op++)
      begin
         case ($urandom_range(0, 9))
            0, 1, 2, 3 : misc_op();
            4          : test32_op();
            5          : time_load_op();
            6, 7       : pps_op();
            default    : unmapped_op();
         endcase
      end

      $display("run done, %0d value errors, %0d bus errors", err_val, err_ack);
      if (err_val + err_ack == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: verilog.f
rtl/u1e_pkg.sv
rtl/wb_intercon.sv
rtl/misc_regs.sv
rtl/settings_bus_16le.sv
rtl/time_64bit.sv
rtl/readback_mux_16le.sv
rtl/u1e_core.sv
tests/tb_clk_gen.sv
tests/tb_u1e_core.sv
